// File: logic/cpu_pkg.sv
package cpu_pkg;

    // ****************************************
    // widths
    // ****************************************
    localparam int data_w     = 16;
    localparam int reg_addr_w = 3;
    // widest APB address a top level may ask for
    localparam int paddr_w    = 32;

    // ****************************************
    // instruction set
    // ****************************************
    // [15:12] opcode, [11:9] rx, [8:6] ry, [5:3] rz
    // imm8 in [7:0], imm5 in [4:0] for loads and stores
    typedef enum logic [3:0] {
        op_nop   = 4'h0,
        op_addu  = 4'h1,
        op_subu  = 4'h2,
        op_and   = 4'h3,
        op_or    = 4'h4,
        op_addiu = 4'h5,
        op_li    = 4'h6,
        op_lw    = 4'h7,
        op_sw    = 4'h8,
        op_beqz  = 4'h9,
        op_b     = 4'ha,
        op_halt  = 4'hf
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_zero;
        logic    branch_always;
        logic    halt;
    } ctrl_t;

    // ****************************************
    // pipeline records
    // ****************************************
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] pc;
        logic [data_w-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [data_w-1:0]     pc;
        logic [reg_addr_w-1:0] rs_a;
        logic [reg_addr_w-1:0] rs_b;
        logic [reg_addr_w-1:0] rd;
        logic [data_w-1:0]     a;
        logic [data_w-1:0]     b;
        logic [data_w-1:0]     imm;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] rd;
        logic [data_w-1:0]     result;
        logic [data_w-1:0]     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [data_w-1:0]     data;
    } wb_t;

    // APB without error signalling
    typedef struct packed {
        logic [paddr_w-1:0] paddr;
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [data_w-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

endpackage

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [cpu_pkg::data_w-1:0] reset_pc = '0
) (
    input  logic                       clk_50MHz,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       mem_busy,
    input  logic                       redirect,
    input  logic [cpu_pkg::data_w-1:0] redirect_pc,
    input  logic [cpu_pkg::data_w-1:0] imem_data,
    output logic [cpu_pkg::data_w-1:0] imem_addr,
    output cpu_pkg::if_id_t            if_id,
    output logic                       halted
);
    import cpu_pkg::*;

    logic [data_w-1:0] pc;
    logic              hold;
    logic              fetch_halt;
    logic              halt_pend;
    logic              drain;

    assign imem_addr  = pc;
    assign hold       = stall || mem_busy;
    assign fetch_halt = opcode_e'(imem_data[15:12]) == op_halt;

    // halt_pend marks a fetched HALT with the pc frozen on it
    // drain marks HALT gone on to execute, past the branches after the next advance
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc        <= reset_pc;
            if_id     <= '0;
            halt_pend <= 1'b0;
            drain     <= 1'b0;
            halted    <= 1'b0;
        end else if (redirect) begin
            // an older branch may still cancel a fetched HALT
            pc          <= redirect_pc;
            if_id.valid <= 1'b0;
            halt_pend   <= 1'b0;
        end else if (!hold) begin
            if (halt_pend) begin
                if_id.valid <= 1'b0;
                drain       <= 1'b1;
                if (drain) begin
                    halted <= 1'b1;
                end
            end else begin
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.inst  <= imem_data;
                halt_pend   <= fetch_halt;
                if (!fetch_halt) begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    // nothing older than HALT is left to branch once halted rises
    halt_no_redirect: assert property (@(posedge clk_50MHz) disable iff (!rst)
        halted |-> !redirect);

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic             clk_50MHz,
    input  logic             rst,
    input  cpu_pkg::if_id_t  if_id,
    input  cpu_pkg::wb_t     wb,
    input  logic             redirect,
    input  logic             mem_busy,
    output cpu_pkg::id_ex_t  id_ex,
    output logic             stall
);
    import cpu_pkg::*;

    logic [data_w-1:0]     regs [0:(1 << reg_addr_w) - 1];
    opcode_e               opcode;
    logic [reg_addr_w-1:0] rx;
    logic [reg_addr_w-1:0] ry;
    logic [reg_addr_w-1:0] rz;
    logic [reg_addr_w-1:0] rd;
    ctrl_t                 ctrl;
    logic                  uses_a;
    logic                  uses_b;
    logic [data_w-1:0]     imm;
    logic [data_w-1:0]     val_a;
    logic [data_w-1:0]     val_b;
    logic                  hazard;

    assign opcode = opcode_e'(if_id.inst[15:12]);
    assign rx     = if_id.inst[11:9];
    assign ry     = if_id.inst[8:6];
    assign rz     = if_id.inst[5:3];

    // ****************************************
    // control decode
    // ****************************************
    always_comb begin
        ctrl   = '0;
        rd     = rz;
        uses_a = 1'b0;
        uses_b = 1'b0;
        imm    = {{(data_w - 8){if_id.inst[7]}}, if_id.inst[7:0]};
        case (opcode)
            op_addu, op_subu, op_and, op_or: begin
                ctrl.reg_write = 1'b1;
                uses_a         = 1'b1;
                uses_b         = 1'b1;
                case (opcode)
                    op_subu: ctrl.alu_op = alu_sub;
                    op_and:  ctrl.alu_op = alu_and;
                    op_or:   ctrl.alu_op = alu_or;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_addiu: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_a         = 1'b1;
                rd             = rx;
            end
            op_li: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = alu_pass_b;
                rd             = rx;
            end
            op_lw: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_a         = 1'b1;
                rd             = ry;
                imm            = {{(data_w - 5){if_id.inst[4]}}, if_id.inst[4:0]};
            end
            op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_a         = 1'b1;
                uses_b         = 1'b1;
                imm            = {{(data_w - 5){if_id.inst[4]}}, if_id.inst[4:0]};
            end
            op_beqz: begin
                ctrl.branch_zero = 1'b1;
                uses_a           = 1'b1;
            end
            op_b:    ctrl.branch_always = 1'b1;
            op_halt: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // ****************************************
    // register file
    // ****************************************
    always_ff @(posedge clk_50MHz) begin
        if (wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through on the same cycle
    assign val_a = (wb.we && wb.rd == rx) ? wb.data : regs[rx];
    assign val_b = (wb.we && wb.rd == ry) ? wb.data : regs[ry];

    // load in execute feeding this instruction
    assign hazard = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read &&
                    ((uses_a && id_ex.rd == rx) || (uses_b && id_ex.rd == ry));
    assign stall  = hazard && !mem_busy;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex <= '0;
        end else if (mem_busy) begin
            // held entry still catches a result retiring under it
            if (wb.we && wb.rd == id_ex.rs_a) begin
                id_ex.a <= wb.data;
            end
            if (wb.we && wb.rd == id_ex.rs_b) begin
                id_ex.b <= wb.data;
            end
        end else if (redirect || stall || !if_id.valid) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            id_ex.valid <= 1'b1;
            id_ex.ctrl  <= ctrl;
            id_ex.pc    <= if_id.pc;
            id_ex.rs_a  <= rx;
            id_ex.rs_b  <= ry;
            id_ex.rd    <= rd;
            id_ex.a     <= val_a;
            id_ex.b     <= val_b;
            id_ex.imm   <= imm;
        end
    end

    // the stalled instruction waits in decode for exactly one cycle
    stall_one_cycle: assert property (@(posedge clk_50MHz) disable iff (!rst)
        stall |=> !stall && $stable(if_id));

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                       clk_50MHz,
    input  logic                       rst,
    input  cpu_pkg::id_ex_t            id_ex,
    input  cpu_pkg::wb_t               wb,
    input  logic                       mem_busy,
    output cpu_pkg::ex_mem_t           ex_mem,
    output logic                       redirect,
    output logic [cpu_pkg::data_w-1:0] redirect_pc
);
    import cpu_pkg::*;

    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] alu_b;
    logic [data_w-1:0] result;
    logic              taken;

    // newest producer wins; a load result is not ready in ex_mem
    function automatic logic [data_w-1:0] forward(
        input ex_mem_t               em,
        input wb_t                   w,
        input logic [reg_addr_w-1:0] rs,
        input logic [data_w-1:0]     reg_val
    );
        if (em.valid && em.ctrl.reg_write && !em.ctrl.mem_read && em.rd == rs) begin
            return em.result;
        end else if (w.we && w.rd == rs) begin
            return w.data;
        end
        return reg_val;
    endfunction

    assign op_a  = forward(ex_mem, wb, id_ex.rs_a, id_ex.a);
    assign op_b  = forward(ex_mem, wb, id_ex.rs_b, id_ex.b);
    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

    // ****************************************
    // ALU
    // ****************************************
    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add: result = op_a + alu_b;
            alu_sub: result = op_a - alu_b;
            alu_and: result = op_a & alu_b;
            alu_or:  result = op_a | alu_b;
            default: result = alu_b;
        endcase
    end

    // branch resolve on rx for BEQZ
    assign taken = id_ex.valid &&
                   (id_ex.ctrl.branch_always || (id_ex.ctrl.branch_zero && op_a == '0));
    // only act on a cycle where the pipe moves
    assign redirect    = taken && !mem_busy;
    assign redirect_pc = id_ex.pc + data_w'(1) + id_ex.imm;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_mem <= '0;
        end else if (!mem_busy) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.result     <= result;
            ex_mem.store_data <= op_b;
        end
    end

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int addr_w = 16
) (
    input  logic              clk_50MHz,
    input  logic              rst,
    input  cpu_pkg::ex_mem_t  ex_mem,
    input  cpu_pkg::apb_rsp_t apb_rsp,
    output cpu_pkg::apb_req_t apb_req,
    output logic              mem_busy,
    output cpu_pkg::wb_t      wb
);
    import cpu_pkg::*;

    typedef enum logic {
        st_setup,
        st_access
    } apb_state_e;

    apb_state_e        state;
    logic              mem_op;
    logic              done;
    logic [addr_w-1:0] eff_addr;

    assign mem_op   = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);
    assign done     = state == st_access && apb_rsp.pready;
    assign mem_busy = mem_op && !done;
    // addr_w must not exceed paddr_w
    assign eff_addr = addr_w'(ex_mem.result);

    // ****************************************
    // APB master
    // ****************************************
    // request fields come straight from ex_mem, which holds while busy
    always_comb begin
        apb_req.paddr   = paddr_w'(eff_addr);
        apb_req.psel    = mem_op;
        apb_req.penable = mem_op && state == st_access;
        apb_req.pwrite  = ex_mem.ctrl.mem_write;
        apb_req.pwdata  = ex_mem.store_data;
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            state <= st_setup;
        end else if (mem_op && state == st_setup) begin
            state <= st_access;
        end else if (done) begin
            state <= st_setup;
        end
    end

    // writeback record
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb <= '0;
        end else if (mem_busy) begin
            wb.we <= 1'b0;
        end else begin
            wb.we   <= ex_mem.valid && ex_mem.ctrl.reg_write;
            wb.rd   <= ex_mem.rd;
            wb.data <= ex_mem.ctrl.mem_read ? apb_rsp.prdata : ex_mem.result;
        end
    end

    apb_stable: assert property (@(posedge clk_50MHz) disable iff (!rst)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready)
        |=> apb_req.psel && $stable(apb_req.paddr) && $stable(apb_req.pwdata));

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [cpu_pkg::data_w-1:0] reset_pc = '0,
    parameter int                         addr_w   = 16
) (
    input  logic                        clk_50MHz,
    input  logic                        rst,
    input  logic [cpu_pkg::data_w-1:0]  imem_data,
    output logic [cpu_pkg::data_w-1:0]  imem_addr,
    output logic                        halted,
    output cpu_pkg::apb_req_t           apb_req,
    input  cpu_pkg::apb_rsp_t           apb_rsp
);
    import cpu_pkg::*;

    if_id_t            if_id;
    id_ex_t            id_ex;
    ex_mem_t           ex_mem;
    wb_t               wb;
    logic              stall;
    logic              mem_busy;
    logic              redirect;
    logic [data_w-1:0] redirect_pc;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) fetch_stage_i (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .stall      (stall),
        .mem_busy   (mem_busy),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .if_id      (if_id),
        .halted     (halted)
    );

    decode_stage decode_stage_i (
        .clk_50MHz(clk_50MHz),
        .rst      (rst),
        .if_id    (if_id),
        .wb       (wb),
        .redirect (redirect),
        .mem_busy (mem_busy),
        .id_ex    (id_ex),
        .stall    (stall)
    );

    execute_stage execute_stage_i (
        .clk_50MHz  (clk_50MHz),
        .rst        (rst),
        .id_ex      (id_ex),
        .wb         (wb),
        .mem_busy   (mem_busy),
        .ex_mem     (ex_mem),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

    mem_stage #(
        .addr_w(addr_w)
    ) mem_stage_i (
        .clk_50MHz(clk_50MHz),
        .rst      (rst),
        .ex_mem   (ex_mem),
        .apb_rsp  (apb_rsp),
        .apb_req  (apb_req),
        .mem_busy (mem_busy),
        .wb       (wb)
    );

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam logic [data_w-1:0] reset_pc    = 16'h0010;
    localparam int                addr_w      = 16;
    localparam int                rom_depth   = 64;
    localparam int                dmem_depth  = 256;
    localparam int                store_limit = 2000;
    localparam int                halt_limit  = 200;
    localparam logic [15:0]       lfsr_seed   = 16'd42255;
    localparam logic [15:0]       halt_word   = 16'hf000;

    logic              clk_50MHz;
    logic              rst;
    logic [data_w-1:0] imem_data;
    logic [data_w-1:0] imem_addr;
    logic              halted;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;

    logic [data_w-1:0] rom [0:rom_depth-1];
    logic [data_w-1:0] dmem [0:dmem_depth-1];
    logic [data_w-1:0] exp_addr [$];
    logic [data_w-1:0] exp_data [$];

    int value_errors = 0;
    int other_errors = 0;
    int write_count  = 0;

    cpu_top #(
        .reset_pc(reset_pc),
        .addr_w  (addr_w)
    ) cpu_top_i (
        .clk_50MHz(clk_50MHz),
        .rst      (rst),
        .imem_data(imem_data),
        .imem_addr(imem_addr),
        .halted   (halted),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    // instruction ROM reads HALT past the program
    assign imem_data = (imem_addr < rom_depth) ? rom[imem_addr[5:0]] : halt_word;

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        other_errors++;
        $display("failure: %s", what);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // ****************************************
    // golden file
    // ****************************************
    task automatic load_golden();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  kind;
        logic [15:0] addr;
        logic [15:0] value;
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = halt_word;
        end
        // background pattern under the d lines
        for (int i = 0; i < dmem_depth; i++) begin
            dmem[i] = 16'(i) ^ 16'ha5c3;
        end
        fd = $fopen("tb/cpu_golden.txt", "r");
        if (fd == 0) begin
            note_failure("could not open tb/cpu_golden.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%c %h %h", kind, addr, value);
            if (fields == 3) begin
                case (kind)
                    "p": begin
                        if (addr < rom_depth) begin
                            rom[addr[5:0]] = value;
                        end else begin
                            note_failure("program word outside the ROM");
                        end
                    end
                    "d": begin
                        if (addr < dmem_depth) begin
                            dmem[addr[7:0]] = value;
                        end else begin
                            note_failure("data word outside the slave memory");
                        end
                    end
                    "s": begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(value);
                    end
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    endtask

    // ****************************************
    // APB slave with random wait states
    // ****************************************
    initial begin
        logic [1:0]         waits;
        logic [15:0]        lfsr;
        logic               in_xfer;
        logic [paddr_w-1:0] xfer_addr;
        logic               xfer_write;
        logic [data_w-1:0]  xfer_data;
        logic [7:0]         idx;
        apb_rsp = '0;
        lfsr    = lfsr_seed;
        waits   = '0;
        in_xfer = 1'b0;
        forever begin
            @(negedge clk_50MHz);
            if (!rst) begin
                apb_rsp = '0;
                in_xfer = 1'b0;
            end else if (apb_req.psel && !apb_req.penable) begin
                if (in_xfer) begin
                    note_failure("setup phase lasted more than one cycle");
                end
                in_xfer    = 1'b1;
                xfer_addr  = apb_req.paddr;
                xfer_write = apb_req.pwrite;
                xfer_data  = apb_req.pwdata;
                lfsr       = lfsr_next(lfsr);
                waits[0]   = lfsr[0];
                lfsr       = lfsr_next(lfsr);
                waits[1]   = lfsr[0];
                apb_rsp.pready = 1'b0;
            end else if (apb_req.psel) begin
                if (!in_xfer) begin
                    note_failure("access phase without a setup phase");
                end
                check_value("apb paddr stable", xfer_addr, apb_req.paddr);
                check_value("apb pwrite stable", 32'(xfer_write), 32'(apb_req.pwrite));
                check_value("apb pwdata stable", 32'(xfer_data), 32'(apb_req.pwdata));
                if (waits != 2'd0) begin
                    waits          = waits - 2'd1;
                    apb_rsp.pready = 1'b0;
                end else begin
                    if (xfer_addr >= dmem_depth) begin
                        note_failure("APB address outside the slave memory");
                    end
                    idx = xfer_addr[7:0];
                    if (xfer_write) begin
                        dmem[idx] = xfer_data;
                        if (write_count < exp_addr.size()) begin
                            check_value($sformatf("store %0d address", write_count),
                                        32'(exp_addr[write_count]), xfer_addr);
                            check_value($sformatf("store %0d data", write_count),
                                        32'(exp_data[write_count]), 32'(xfer_data));
                        end else begin
                            note_failure("store beyond the end of the golden list");
                        end
                        write_count++;
                    end else begin
                        apb_rsp.prdata = dmem[idx];
                    end
                    apb_rsp.pready = 1'b1;
                    in_xfer        = 1'b0;
                end
            end else begin
                if (apb_req.penable) begin
                    note_failure("penable high without psel");
                end
                if (in_xfer) begin
                    note_failure("psel dropped before pready");
                end
                apb_rsp.pready = 1'b0;
                in_xfer        = 1'b0;
            end
        end
    end

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        int cycles;
        rst = 1'b0;
        load_golden();
        repeat (10) @(negedge clk_50MHz);
        check_value("reset psel", 32'd0, 32'(apb_req.psel));
        check_value("reset penable", 32'd0, 32'(apb_req.penable));
        check_value("reset halted", 32'd0, 32'(halted));
        check_value("reset imem_addr", 32'(reset_pc), 32'(imem_addr));
        rst = 1'b1;

        cycles = 0;
        while (write_count < exp_addr.size() && cycles < store_limit) begin
            @(posedge clk_50MHz);
            cycles++;
        end
        if (write_count < exp_addr.size()) begin
            note_failure("timed out waiting for the expected stores");
        end

        cycles = 0;
        while (!halted && cycles < halt_limit) begin
            @(negedge clk_50MHz);
            cycles++;
        end
        if (!halted) begin
            note_failure("timed out waiting for halted");
        end

        // bus must stay quiet once halted
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_50MHz);
            if (apb_req.psel) begin
                note_failure("APB transfer after halted rose");
            end
        end
        check_value("store count", 32'(exp_addr.size()), 32'(write_count));
        check_value("halted held", 32'd1, 32'(halted));

        $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/cpu_golden.txt
# kind address value, all hex
# p = program word, d = initial data word, s = expected store in order
p 0010 6212
p 0011 6434
p 0012 1298
p 0013 2660
p 0014 3728
p 0015 4a70
p 0016 5cff
p 0017 6e40
p 0018 8ec0
p 0019 8f01
p 001a 8f42
p 001b 8f83
p 001c 7e48
p 001d 1298
p 001e 8ec4
p 001f 7e9f
p 0020 8e85
p 0021 6000
p 0022 9002
p 0023 8e46
p 0024 8e47
p 0025 9202
p 0026 8f06
p 0027 a003
p 0028 8e47
p 0029 8e48
p 002a 8e49
p 002b 8f87
p 002c f000
d 0048 1234
d 003f beef
s 0040 0046
s 0041 0034
s 0042 0004
s 0043 0015
s 0044 1268
s 0045 beef
s 0046 0034
s 0047 0015

// File: verilog.f
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/cpu_top.sv
tb/cpu_tb.sv

// File: Makefile
# Verilator build and run of the cpu testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f verilog.f -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
